// ==== src/zeus_settings.svh ====
`ifndef ZEUS_SETTINGS_SVH
`define ZEUS_SETTINGS_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define ZEUS_ADDR_W      24          // Wishbone address bits
`define ZEUS_DATA_W      8           // Byte wide data path
`define ZEUS_IO_ADDR_W   16          // External peripheral address bits
`define ZEUS_WIN_W       5           // 32 byte peripheral windows

// ----------------------------------------------------------
// Address map
// ----------------------------------------------------------
`define ZEUS_EXP1_BASE   24'h00BF00
`define ZEUS_EXP2_BASE   24'h00BF20
`define ZEUS_AUDIO_BASE  24'h00BF40
`define ZEUS_MMU_BASE    24'h00BFE0
`define ZEUS_ROM_FIRST   24'h00C000  // ROM seen through the IO bridge
`define ZEUS_ROM_LAST    24'h01BFFF
`define ZEUS_VRAM_FIRST  24'hFE0000  // Runs to top of address space

`define ZEUS_RAM_AW      10          // On-chip RAM depth, aliases above
`define ZEUS_VRAM_AW     10          // On-chip VRAM depth, aliases above

`endif

// ==== src/zeus_pkg.sv ====
package zeus_pkg;

	// ----------------------------------------------------------
	// Bus targets
	// ----------------------------------------------------------

	// One entry per decoded window
	typedef enum logic [2:0] {
		TGT_EXP1  = 3'd0,  // Expansion slot 1 on the IO bus
		TGT_EXP2  = 3'd1,  // Expansion slot 2 on the IO bus
		TGT_AUDIO = 3'd2,  // Audio controller on the IO bus
		TGT_ROM   = 3'd3,  // External ROM, reads only
		TGT_MMU   = 3'd4,  // Memory management registers
		TGT_VRAM  = 3'd5,  // Video memory store
		TGT_RAM   = 3'd6   // Default target
	} target_e;

	// ----------------------------------------------------------
	// IO bridge handshake
	// ----------------------------------------------------------

	// Four phase request and acknowledge
	typedef enum logic [1:0] {
		IO_IDLE    = 2'd0,  // Waiting for a strobe
		IO_REQ     = 2'd1,  // Request low until device acks
		IO_RELEASE = 2'd2,  // Request high until device lets go
		IO_DONE    = 2'd3   // Ack cycle, master drops stb
	} io_state_e;

endpackage

// ==== src/bus_decoder.sv ====
`timescale 1ns/1ps
`include "zeus_settings.svh"

module bus_decoder (
	input  logic [`ZEUS_ADDR_W-1:0] wb_adr_i,
	input  logic                    wb_we_i,
	input  logic                    rom_disabled_i,
	input  logic                    vram_disabled_i,
	output zeus_pkg::target_e       target_sel_o
);
	import zeus_pkg::*;

	logic hit_exp1;
	logic hit_exp2;
	logic hit_audio;
	logic hit_mmu;
	logic hit_rom;
	logic hit_vram;

	// Compare everything above the window offset
	function automatic logic in_window(
		input logic [`ZEUS_ADDR_W-1:0] adr,
		input logic [`ZEUS_ADDR_W-1:0] base
	);
		return adr[`ZEUS_ADDR_W-1:`ZEUS_WIN_W] == base[`ZEUS_ADDR_W-1:`ZEUS_WIN_W];
	endfunction

	// ----------------------------------------------------------
	// Window hits
	// ----------------------------------------------------------
	assign hit_exp1  = in_window(wb_adr_i, `ZEUS_EXP1_BASE);
	assign hit_exp2  = in_window(wb_adr_i, `ZEUS_EXP2_BASE);
	assign hit_audio = in_window(wb_adr_i, `ZEUS_AUDIO_BASE);
	assign hit_mmu   = in_window(wb_adr_i, `ZEUS_MMU_BASE);

	// Writes into ROM range fall to RAM
	assign hit_rom = !rom_disabled_i && !wb_we_i
		&& (wb_adr_i >= `ZEUS_ROM_FIRST) && (wb_adr_i <= `ZEUS_ROM_LAST);

	// No upper bound needed, window ends at top of map
	assign hit_vram = !vram_disabled_i && (wb_adr_i >= `ZEUS_VRAM_FIRST);

	// ----------------------------------------------------------
	// Priority select
	// ----------------------------------------------------------
	always_comb begin
		if (hit_exp1)
			target_sel_o = TGT_EXP1;
		else if (hit_exp2)
			target_sel_o = TGT_EXP2;
		else if (hit_audio)
			target_sel_o = TGT_AUDIO;
		else if (hit_mmu)
			target_sel_o = TGT_MMU;          // Before ROM so regs stay reachable
		else if (hit_rom)
			target_sel_o = TGT_ROM;
		else if (hit_vram)
			target_sel_o = TGT_VRAM;
		else
			target_sel_o = TGT_RAM;          // Dropped peripheral windows land here too
	end

endmodule

// ==== src/bus_intercon.sv ====
`timescale 1ns/1ps
`include "zeus_settings.svh"

module bus_intercon (
	input  logic                    wb_stb_i,
	input  logic                    wb_cyc_i,
	input  zeus_pkg::target_e       target_sel_i,
	output logic                    io_stb_o,
	output logic                    mmu_stb_o,
	output logic                    vram_stb_o,
	output logic                    ram_stb_o,
	input  logic                    io_ack_i,
	input  logic                    mmu_ack_i,
	input  logic                    vram_ack_i,
	input  logic                    ram_ack_i,
	input  logic [`ZEUS_DATA_W-1:0] io_dat_i,
	input  logic [`ZEUS_DATA_W-1:0] mmu_dat_i,
	input  logic [`ZEUS_DATA_W-1:0] vram_dat_i,
	input  logic [`ZEUS_DATA_W-1:0] ram_dat_i,
	output logic                    wb_ack_o,
	output logic [`ZEUS_DATA_W-1:0] wb_dat_o
);
	import zeus_pkg::*;

	logic stb;          // Strobe qualified by cycle
	logic [3:0] acks;   // Raw acks from every target

	assign stb  = wb_stb_i && wb_cyc_i;
	assign acks = {io_ack_i, mmu_ack_i, vram_ack_i, ram_ack_i};

	// ----------------------------------------------------------
	// Strobe steering and return mux
	// ----------------------------------------------------------
	always_comb begin
		io_stb_o   = 1'b0;
		mmu_stb_o  = 1'b0;
		vram_stb_o = 1'b0;
		ram_stb_o  = 1'b0;
		wb_ack_o   = 1'b0;
		wb_dat_o   = '0;           // Unselected targets read as zero

		case (target_sel_i)
			TGT_EXP1, TGT_EXP2, TGT_AUDIO, TGT_ROM: begin
				io_stb_o = stb;         // All external windows share the bridge
				wb_ack_o = io_ack_i;
				wb_dat_o = io_dat_i;
			end
			TGT_MMU: begin
				mmu_stb_o = stb;
				wb_ack_o  = mmu_ack_i;
				wb_dat_o  = mmu_dat_i;
			end
			TGT_VRAM: begin
				vram_stb_o = stb;
				wb_ack_o   = vram_ack_i;
				wb_dat_o   = vram_dat_i;
			end
			default: begin
				ram_stb_o = stb;
				wb_ack_o  = ram_ack_i;
				wb_dat_o  = ram_dat_i;
			end
		endcase
	end

	// Targets only ack while the master still holds strobe
	always_comb begin
		assert (stb || ((|acks) !== 1'b1))
			else $error("target ack seen without a bus strobe");
	end

endmodule

// ==== src/mmu_regs.sv ====
`timescale 1ns/1ps
`include "zeus_settings.svh"

module mmu_regs (
	input  logic                    wb_clk_i,
	input  logic                    reset_i,
	input  logic                    stb_i,
	input  logic                    wb_we_i,
	input  logic [`ZEUS_WIN_W-1:0]  wb_adr_i,
	input  logic [`ZEUS_DATA_W-1:0] wb_dat_i,
	output logic                    ack_o,
	output logic [`ZEUS_DATA_W-1:0] dat_o,
	output logic                    rom_disabled_o,
	output logic                    vram_disabled_o
);

	logic [1:0] ctrl_q;     // [0] ROM off, [1] VRAM off
	logic [1:0] ack_sr;     // Accept then ack
	logic       accept;
	logic       sel_ctrl;   // Offset 0 only

	assign accept   = stb_i && !(|ack_sr);  // One accept per transfer
	assign sel_ctrl = (wb_adr_i == '0);

	// ----------------------------------------------------------
	// Control register and handshake
	// ----------------------------------------------------------
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			ctrl_q <= 2'b00;               // ROM and VRAM both mapped
			ack_sr <= 2'b00;
		end else begin
			ack_sr <= {ack_sr[0], accept};
			if (accept && wb_we_i && sel_ctrl)
				ctrl_q <= wb_dat_i[1:0];     // Upper bits dropped
		end
	end

	// Read data captured at accept, held through ack
	always_ff @(posedge wb_clk_i) begin
		if (accept)
			dat_o <= sel_ctrl ? {{(`ZEUS_DATA_W-2){1'b0}}, ctrl_q} : '0;
	end

	assign ack_o           = ack_sr[1];
	assign rom_disabled_o  = ctrl_q[0];
	assign vram_disabled_o = ctrl_q[1];

	// Single cycle ack pulse
	ack_single: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		ack_o |=> !ack_o);

endmodule

// ==== src/async_io_bridge.sv ====
`timescale 1ns/1ps
`include "zeus_settings.svh"

module async_io_bridge (
	input  logic                       wb_clk_i,
	input  logic                       reset_i,
	input  logic                       stb_i,
	input  logic                       wb_we_i,
	input  logic [`ZEUS_ADDR_W-1:0]    wb_adr_i,
	input  logic [`ZEUS_DATA_W-1:0]    wb_dat_i,
	input  zeus_pkg::target_e          target_sel_i,
	output logic                       ack_o,
	output logic [`ZEUS_DATA_W-1:0]    dat_o,
	output logic [`ZEUS_IO_ADDR_W-1:0] io_addr_o,
	output logic [`ZEUS_DATA_W-1:0]    io_data_o,
	output logic                       io_data_oe_o,
	output logic                       io_read_req_n_o,
	output logic                       io_write_req_n_o,
	output logic                       io_exp1_n_o,
	output logic                       io_exp2_n_o,
	output logic                       io_audio_n_o,
	output logic                       io_rom_n_o,
	input  logic [`ZEUS_DATA_W-1:0]    io_data_i,
	input  logic                       io_ack_n_i
);
	import zeus_pkg::*;

	io_state_e                  state_q;
	logic [1:0]                 ack_n_sync_q;  // [1] is safe to use
	logic                       ack_seen;      // Device ack, synced
	logic                       start;
	logic [`ZEUS_ADDR_W-1:0]    rom_off;
	logic [`ZEUS_IO_ADDR_W-1:0] next_addr;

	assign ack_seen = !ack_n_sync_q[1];
	assign start    = (state_q == IO_IDLE) && stb_i;
	assign rom_off  = wb_adr_i - `ZEUS_ROM_FIRST;   // ROM starts at external 0000

	// Peripherals only see their window offset
	always_comb begin
		if (target_sel_i == TGT_ROM)
			next_addr = rom_off[`ZEUS_IO_ADDR_W-1:0];
		else
			next_addr = {{(`ZEUS_IO_ADDR_W-`ZEUS_WIN_W){1'b0}}, wb_adr_i[`ZEUS_WIN_W-1:0]};
	end

	// Device ack is asynchronous
	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			ack_n_sync_q <= 2'b11;
		else
			ack_n_sync_q <= {ack_n_sync_q[0], io_ack_n_i};
	end

	// ----------------------------------------------------------
	// Handshake FSM
	// ----------------------------------------------------------
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			state_q          <= IO_IDLE;
			ack_o            <= 1'b0;
			io_data_oe_o     <= 1'b0;
			io_read_req_n_o  <= 1'b1;
			io_write_req_n_o <= 1'b1;
			io_exp1_n_o      <= 1'b1;
			io_exp2_n_o      <= 1'b1;
			io_audio_n_o     <= 1'b1;
			io_rom_n_o       <= 1'b1;
		end else begin
			ack_o <= 1'b0;                  // Pulse only
			case (state_q)
				IO_IDLE: if (start) begin
					io_read_req_n_o  <= wb_we_i;
					io_write_req_n_o <= !wb_we_i;
					io_data_oe_o     <= wb_we_i;  // Drive bus on writes
					io_exp1_n_o      <= (target_sel_i != TGT_EXP1);
					io_exp2_n_o      <= (target_sel_i != TGT_EXP2);
					io_audio_n_o     <= (target_sel_i != TGT_AUDIO);
					io_rom_n_o       <= (target_sel_i != TGT_ROM);
					state_q          <= IO_REQ;
				end
				IO_REQ: if (ack_seen) begin
					io_read_req_n_o  <= 1'b1;     // Data latched this edge
					io_write_req_n_o <= 1'b1;
					state_q          <= IO_RELEASE;
				end
				IO_RELEASE: if (!ack_seen) begin
					io_data_oe_o <= 1'b0;
					io_exp1_n_o  <= 1'b1;
					io_exp2_n_o  <= 1'b1;
					io_audio_n_o <= 1'b1;
					io_rom_n_o   <= 1'b1;
					ack_o        <= 1'b1;
					state_q      <= IO_DONE;
				end
				default: state_q <= IO_IDLE;    // IO_DONE lets stb drop
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge wb_clk_i) begin
		if (start) begin
			io_addr_o <= next_addr;
			io_data_o <= wb_dat_i;
		end
		if ((state_q == IO_REQ) && ack_seen)
			dat_o <= io_data_i;
	end

	req_exclusive: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		io_read_req_n_o || io_write_req_n_o);

	// A live request always has exactly one chip select
	req_has_cs: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		!(io_read_req_n_o && io_write_req_n_o)
		|-> $countones({io_exp1_n_o, io_exp2_n_o, io_audio_n_o, io_rom_n_o}) == 3);

endmodule

// ==== src/local_ram.sv ====
`timescale 1ns/1ps
`include "zeus_settings.svh"

module local_ram #(
	parameter int ADDR_W = 10                  // Depth in address bits
) (
	input  logic                    wb_clk_i,
	input  logic                    reset_i,
	input  logic                    stb_i,
	input  logic                    wb_we_i,
	input  logic [ADDR_W-1:0]       wb_adr_i,
	input  logic [`ZEUS_DATA_W-1:0] wb_dat_i,
	output logic                    ack_o,
	output logic [`ZEUS_DATA_W-1:0] dat_o
);

	logic [`ZEUS_DATA_W-1:0] mem [0:(2**ADDR_W)-1];
	logic [1:0]              ack_sr;          // Accept then ack
	logic                    accept;

	assign accept = stb_i && !(|ack_sr);     // Ignore stb while answering

	// ----------------------------------------------------------
	// Ack pipeline
	// ----------------------------------------------------------
	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			ack_sr <= 2'b00;
		else
			ack_sr <= {ack_sr[0], accept};
	end

	assign ack_o = ack_sr[1];

	// Byte array with registered read
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			if (wb_we_i)
				mem[wb_adr_i] <= wb_dat_i;
			dat_o <= mem[wb_adr_i];               // Old data on writes
		end
	end

	ack_single: assert property (@(posedge wb_clk_i) disable iff (reset_i)
		ack_o |=> !ack_o);

endmodule

// ==== src/zeus_top.sv ====
`timescale 1ns/1ps
`include "zeus_settings.svh"

module zeus_top (
	input  logic                       wb_clk_i,
	input  logic                       reset_i,
	// Wishbone classic slave port
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	input  logic                       wb_we_i,
	input  logic [`ZEUS_ADDR_W-1:0]    wb_adr_i,
	input  logic [`ZEUS_DATA_W-1:0]    wb_dat_i,
	output logic [`ZEUS_DATA_W-1:0]    wb_dat_o,
	output logic                       wb_ack_o,
	// External peripheral bus
	output logic                       io_reset_n_o,
	output logic [`ZEUS_IO_ADDR_W-1:0] io_addr_o,
	output logic [`ZEUS_DATA_W-1:0]    io_data_o,
	input  logic [`ZEUS_DATA_W-1:0]    io_data_i,
	output logic                       io_data_oe_o,
	output logic                       io_read_req_n_o,
	output logic                       io_write_req_n_o,
	input  logic                       io_ack_n_i,
	output logic                       io_exp1_n_o,
	output logic                       io_exp2_n_o,
	output logic                       io_audio_n_o,
	output logic                       io_rom_n_o
);
	import zeus_pkg::*;

	target_e                 target_sel;
	logic                    rom_disabled, vram_disabled;
	logic                    io_stb, mmu_stb, vram_stb, ram_stb;
	logic                    io_ack, mmu_ack, vram_ack, ram_ack;
	logic [`ZEUS_DATA_W-1:0] io_dat, mmu_dat, vram_dat, ram_dat;

	assign io_reset_n_o = !reset_i;   // Peripherals held in reset with the core

	// ----------------------------------------------------------
	// Decode and routing
	// ----------------------------------------------------------
	bus_decoder decoder (.wb_adr_i(wb_adr_i), .wb_we_i(wb_we_i),
		.rom_disabled_i(rom_disabled), .vram_disabled_i(vram_disabled),
		.target_sel_o(target_sel));

	bus_intercon intercon (.wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
		.target_sel_i(target_sel), .io_stb_o(io_stb), .mmu_stb_o(mmu_stb),
		.vram_stb_o(vram_stb), .ram_stb_o(ram_stb), .io_ack_i(io_ack),
		.mmu_ack_i(mmu_ack), .vram_ack_i(vram_ack), .ram_ack_i(ram_ack),
		.io_dat_i(io_dat), .mmu_dat_i(mmu_dat), .vram_dat_i(vram_dat),
		.ram_dat_i(ram_dat), .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o));

	// ----------------------------------------------------------
	// Targets
	// ----------------------------------------------------------
	mmu_regs mmu (.wb_clk_i(wb_clk_i), .reset_i(reset_i), .stb_i(mmu_stb),
		.wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i[`ZEUS_WIN_W-1:0]), .wb_dat_i(wb_dat_i),
		.ack_o(mmu_ack), .dat_o(mmu_dat), .rom_disabled_o(rom_disabled),
		.vram_disabled_o(vram_disabled));

	async_io_bridge io_bus (.wb_clk_i(wb_clk_i), .reset_i(reset_i), .stb_i(io_stb),
		.wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.target_sel_i(target_sel), .ack_o(io_ack), .dat_o(io_dat),
		.io_addr_o(io_addr_o), .io_data_o(io_data_o), .io_data_oe_o(io_data_oe_o),
		.io_read_req_n_o(io_read_req_n_o), .io_write_req_n_o(io_write_req_n_o),
		.io_exp1_n_o(io_exp1_n_o), .io_exp2_n_o(io_exp2_n_o),
		.io_audio_n_o(io_audio_n_o), .io_rom_n_o(io_rom_n_o),
		.io_data_i(io_data_i), .io_ack_n_i(io_ack_n_i));

	// Both stores alias modulo their depth
	local_ram #(.ADDR_W(`ZEUS_RAM_AW)) ram_store (.wb_clk_i(wb_clk_i),
		.reset_i(reset_i), .stb_i(ram_stb), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i[`ZEUS_RAM_AW-1:0]), .wb_dat_i(wb_dat_i),
		.ack_o(ram_ack), .dat_o(ram_dat));

	local_ram #(.ADDR_W(`ZEUS_VRAM_AW)) vram_store (.wb_clk_i(wb_clk_i),
		.reset_i(reset_i), .stb_i(vram_stb), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i[`ZEUS_VRAM_AW-1:0]), .wb_dat_i(wb_dat_i),
		.ack_o(vram_ack), .dat_o(vram_dat));

endmodule

// ==== sim/tb_io_device.sv ====
`timescale 1ns/1ps

module tb_io_device (
	input  logic        clk,
	input  logic [2:0]  delay_i,        // Wait cycles for the next answer
	input  logic [15:0] io_addr_i,
	input  logic [7:0]  io_wdata_i,
	output logic [7:0]  io_rdata_o,
	input  logic        read_req_n_i,
	input  logic        write_req_n_i,
	input  logic        exp1_n_i,
	input  logic        exp2_n_i,
	input  logic        audio_n_i,
	input  logic        rom_n_i,
	output logic        ack_n_o
);

	logic [7:0] exp1_m [0:31];
	logic [7:0] exp2_m [0:31];
	logic [7:0] audio_m [0:31];
	logic [7:0] rdata_q = 8'h00;
	logic       ack_q = 1'b1;           // Idle high from time zero
	logic       busy_q = 1'b0;
	logic [2:0] wait_q = 3'd0;

	assign io_rdata_o = rdata_q;
	assign ack_n_o    = ack_q;

	// Four phase slave, ack after a random wait
	always @(posedge clk) begin
		if (!busy_q && ack_q && !(read_req_n_i && write_req_n_i)) begin
			busy_q <= 1'b1;
			wait_q <= delay_i;
		end else if (busy_q) begin
			if (wait_q != 3'd0) begin
				wait_q <= wait_q - 3'd1;
			end else begin
				busy_q <= 1'b0;
				ack_q  <= 1'b0;
				if (!write_req_n_i) begin
					if (!exp1_n_i) exp1_m[io_addr_i[4:0]] <= io_wdata_i;
					if (!exp2_n_i) exp2_m[io_addr_i[4:0]] <= io_wdata_i;
					if (!audio_n_i) audio_m[io_addr_i[4:0]] <= io_wdata_i;
				end else if (!rom_n_i) begin
					rdata_q <= io_addr_i[7:0] ^ io_addr_i[15:8];   // ROM pattern
				end else begin
					rdata_q <= !exp1_n_i ? exp1_m[io_addr_i[4:0]]
						: !exp2_n_i ? exp2_m[io_addr_i[4:0]] : audio_m[io_addr_i[4:0]];
				end
			end
		end else if (!ack_q && read_req_n_i && write_req_n_i) begin
			ack_q <= 1'b1;                  // Release once request drops
		end
	end

endmodule

// ==== sim/tb_zeus.sv ====
`timescale 1ns/1ps
`include "zeus_settings.svh"

module tb_zeus;

	localparam int CYCLE_LIMIT = 600 * 40 + 100;

	logic        clk = 1'b0;
	logic        reset_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
	logic [23:0] wb_adr_i;
	logic [7:0]  wb_dat_i, wb_dat_o, io_data_o, io_data_i;
	logic [15:0] io_addr_o;
	logic        io_reset_n_o, io_data_oe_o, io_read_req_n_o, io_write_req_n_o, io_ack_n_i;
	logic        io_exp1_n_o, io_exp2_n_o, io_audio_n_o, io_rom_n_o;
	logic [2:0]  dev_delay;

	logic [31:0] lfsr_q = 32'h872e_675b;
	logic [7:0]  ram_m [0:1023];        // Reference copies
	logic [7:0]  vram_m [0:1023];
	logic [7:0]  exp_m [0:95];          // Three 32 byte windows
	logic [1:0]  mmu_q;
	string       cur_test;
	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          cyc_cnt = 0;
	logic        rd_pending = 1'b0;
	logic [7:0]  rd_exp;
	logic [3:0]  exp_cs;                // {rom, audio, exp2, exp1} active low
	logic [15:0] exp_ioa;

	always #5 clk = !clk;

	zeus_top dut (.wb_clk_i(clk), .reset_i(reset_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o), .io_reset_n_o(io_reset_n_o), .io_addr_o(io_addr_o),
		.io_data_o(io_data_o), .io_data_i(io_data_i), .io_data_oe_o(io_data_oe_o),
		.io_read_req_n_o(io_read_req_n_o), .io_write_req_n_o(io_write_req_n_o),
		.io_ack_n_i(io_ack_n_i), .io_exp1_n_o(io_exp1_n_o), .io_exp2_n_o(io_exp2_n_o),
		.io_audio_n_o(io_audio_n_o), .io_rom_n_o(io_rom_n_o));

	tb_io_device io_dev (.clk(clk), .delay_i(dev_delay), .io_addr_i(io_addr_o),
		.io_wdata_i(io_data_o), .io_rdata_o(io_data_i), .read_req_n_i(io_read_req_n_o),
		.write_req_n_i(io_write_req_n_o), .exp1_n_i(io_exp1_n_o), .exp2_n_i(io_exp2_n_o),
		.audio_n_i(io_audio_n_o), .rom_n_i(io_rom_n_o), .ack_n_o(io_ack_n_i));

	// ----------------------------------------------------------
	// Random source and reference model
	// ----------------------------------------------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];   // Taps 32 22 2 1
			lfsr_q = {lfsr_q[30:0], fb};
			v      = {v[30:0], fb};
		end
		return v;
	endfunction

	// 0 exp1, 1 exp2, 2 audio, 3 ROM, 4 MMU, 5 VRAM, 6 RAM
	function automatic int region(input logic [23:0] a, input logic we);
		if ((a >> 5) == (`ZEUS_EXP1_BASE >> 5)) return 0;
		if ((a >> 5) == (`ZEUS_EXP2_BASE >> 5)) return 1;
		if ((a >> 5) == (`ZEUS_AUDIO_BASE >> 5)) return 2;
		if ((a >> 5) == (`ZEUS_MMU_BASE >> 5)) return 4;
		if (!we && !mmu_q[0] && a >= `ZEUS_ROM_FIRST && a <= `ZEUS_ROM_LAST) return 3;
		if (!mmu_q[1] && a >= `ZEUS_VRAM_FIRST) return 5;
		return 6;
	endfunction

	function automatic logic [7:0] ref_read(input logic [23:0] a);
		logic [23:0] off;
		int          r;
		off = a - `ZEUS_ROM_FIRST;
		r   = region(a, 1'b0);
		if (r < 3) return exp_m[{r[1:0], a[4:0]}];
		if (r == 3) return off[7:0] ^ off[15:8];
		if (r == 4) return (a[4:0] == 5'd0) ? {6'd0, mmu_q} : 8'h00;
		if (r == 5) return vram_m[a[9:0]];
		return ram_m[a[9:0]];
	endfunction

	task automatic model_write(input logic [23:0] a, input logic [7:0] d);
		int r;
		r = region(a, 1'b1);
		if (r < 3) exp_m[{r[1:0], a[4:0]}] = d;
		else if (r == 4 && a[4:0] == 5'd0) mmu_q = d[1:0];
		else if (r == 5) vram_m[a[9:0]] = d;
		else if (r == 6) ram_m[a[9:0]] = d;
	endtask

	// ----------------------------------------------------------
	// Bus master
	// ----------------------------------------------------------
	task automatic bus_xfer(input logic we, input logic [23:0] a, input logic [7:0] d);
		int          r;
		int          n;
		logic [23:0] off;
		r   = region(a, we);
		off = a - `ZEUS_ROM_FIRST;
		@(negedge clk);
		dev_delay = 3'(rand_bits(3));
		exp_cs    = 4'b1111;
		if (r <= 3) exp_cs[r[1:0]] = 1'b0;
		exp_ioa   = (r == 3) ? off[15:0] : {11'd0, a[4:0]};
		wb_cyc_i  = 1'b1;
		wb_stb_i  = 1'b1;
		wb_we_i   = we;
		wb_adr_i  = a;
		wb_dat_i  = d;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack_o);
		if (r >= 4 && n != 2) begin
			err_cnt++;
			$display("ERR %s latency expected 2 actual %0d", cur_test, n);
		end
		@(negedge clk);                     // Stb drops in the cycle after ack
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
	endtask

	task automatic bus_write(input logic [23:0] a, input logic [7:0] d);
		model_write(a, d);
		bus_xfer(1'b1, a, d);
	endtask

	task automatic bus_read(input logic [23:0] a);
		rd_exp     = ref_read(a);
		rd_pending = 1'b1;
		bus_xfer(1'b0, a, 8'h00);
	endtask

	// ----------------------------------------------------------
	// Checkers
	// ----------------------------------------------------------
	task automatic check_idle_outputs(input logic rst_n_exp);
		if (io_reset_n_o !== rst_n_exp || wb_ack_o !== 1'b0 || io_data_oe_o !== 1'b0
			|| {io_read_req_n_o, io_write_req_n_o} !== 2'b11
			|| {io_exp1_n_o, io_exp2_n_o, io_audio_n_o, io_rom_n_o} !== 4'hF) begin
			err_cnt++;
			$display("%s: bus outputs not idle, io_reset_n_o should be %0b", cur_test, rst_n_exp);
		end
	endtask

	always @(negedge clk) begin
		if (rd_pending && wb_ack_o) begin
			rd_pending = 1'b0;
			chk_cnt++;
			if (wb_dat_o !== rd_exp) begin
				err_cnt++;
				$display("ERR %s expected %02h actual %02h", cur_test, rd_exp, wb_dat_o);
			end
		end
	end

	// External bus rules while a request is live
	always @(negedge clk) begin
		if (!reset_i && !(io_read_req_n_o && io_write_req_n_o)) begin
			if (!io_read_req_n_o && !io_write_req_n_o) begin
				err_cnt++;
				$display("%s: read and write requests are low together", cur_test);
			end
			// Request direction and data drive follow the transfer
			if ({io_read_req_n_o, io_write_req_n_o, io_data_oe_o}
				!== {wb_we_i, !wb_we_i, wb_we_i}) begin
				err_cnt++;
				$display("ERR %s req_n and oe expected %03b actual %03b", cur_test,
					{wb_we_i, !wb_we_i, wb_we_i},
					{io_read_req_n_o, io_write_req_n_o, io_data_oe_o});
			end
			if ({io_rom_n_o, io_audio_n_o, io_exp2_n_o, io_exp1_n_o} !== exp_cs) begin
				err_cnt++;
				$display("ERR %s selects expected %04b actual %04b", cur_test, exp_cs,
					{io_rom_n_o, io_audio_n_o, io_exp2_n_o, io_exp1_n_o});
			end
			if (io_addr_o !== exp_ioa) begin
				err_cnt++;
				$display("ERR %s io_addr expected %04h actual %04h", cur_test, exp_ioa, io_addr_o);
			end
		end
	end

	always @(posedge clk) begin
		cyc_cnt++;
		if (cyc_cnt >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles, a transfer never finished", cyc_cnt);
			$display("tests failed");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial begin
		logic [23:0] a;
		logic [23:0] rd_q[$];
		reset_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		dev_delay = 3'd0;
		mmu_q = 2'b00;
		cur_test = "reset";
		repeat (4) @(negedge clk);
		check_idle_outputs(1'b0);           // External reset held low
		repeat (12) @(negedge clk);
		reset_i = 1'b0;
		@(negedge clk);
		check_idle_outputs(1'b1);           // Idle before the first transfer

		cur_test = "ram_random";           // Low RAM, dropped windows, ROM writes, high alias
		for (int i = 0; i < 100; i++) begin
			case (rand_bits(2))
				0: a = 24'(rand_bits(10));
				1: a = 24'h00BF60 + 24'(rand_bits(7));
				2: a = `ZEUS_ROM_FIRST + 24'(rand_bits(16));
				default: a = 24'h020000 | 24'(rand_bits(23));
			endcase
			bus_write(a, 8'(rand_bits(8)));
			rd_q.push_back((a >= `ZEUS_ROM_FIRST && a <= `ZEUS_ROM_LAST) ? {14'd0, a[9:0]} : a);
		end
		while (rd_q.size() > 0) bus_read(rd_q.pop_front());

		cur_test = "io_windows";
		for (int w = 0; w < 3; w++) begin
			for (int i = 0; i < 8; i++) begin
				a = 24'(`ZEUS_EXP1_BASE + w * 32 + rand_bits(5));
				bus_write(a, 8'(rand_bits(8)));
				rd_q.push_back(a);
			end
		end
		while (rd_q.size() > 0) bus_read(rd_q.pop_front());

		cur_test = "rom_read";
		for (int i = 0; i < 40; i++) bus_read(`ZEUS_ROM_FIRST + 24'(rand_bits(16)));

		cur_test = "mmu_rom_off";
		bus_write(`ZEUS_MMU_BASE, 8'hFD);
		bus_read(`ZEUS_MMU_BASE);
		bus_read(`ZEUS_MMU_BASE + 24'd5);
		for (int i = 0; i < 16; i++) begin
			a = `ZEUS_ROM_FIRST + 24'(rand_bits(16));
			bus_write(a, 8'(rand_bits(8)));
			bus_read(a);
		end

		cur_test = "vram_split";
		bus_write(`ZEUS_MMU_BASE, 8'h00);
		for (int i = 0; i < 16; i++) begin
			a = `ZEUS_VRAM_FIRST + 24'(rand_bits(17));
			bus_write(a, 8'(rand_bits(8)));
			bus_write({14'd0, a[9:0]}, 8'(rand_bits(8)));
			rd_q.push_back(a);
		end
		foreach (rd_q[i]) bus_read(rd_q[i]);
		bus_write(`ZEUS_MMU_BASE, 8'h02);
		bus_read(`ZEUS_MMU_BASE);
		while (rd_q.size() > 0) bus_read(rd_q.pop_front());

		repeat (4) @(negedge clk);
		$display("Checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+src
src/zeus_pkg.sv
src/bus_decoder.sv
src/bus_intercon.sv
src/mmu_regs.sv
src/async_io_bridge.sv
src/local_ram.sv
src/zeus_top.sv
sim/tb_io_device.sv
sim/tb_zeus.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_zeus
FILELIST   := tb.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
